// File: lau_pkg.sv
// lau comparator package
// prefix speed and opcode encodings, word width, request and result records
package lau_pkg;

	// prefix network architecture
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // serial chain
		MEDIUM = 2'b01, // brent-kung tree
		FAST   = 2'b10  // sklansky tree
	} speed_e;

	// comparator operations
	typedef enum logic [2:0] {
		OP_GEU  = 3'd0, // a >= b unsigned
		OP_LTU  = 3'd1, // a < b unsigned
		OP_EQ   = 3'd2, // a == b
		OP_GES  = 3'd3, // a >= b signed
		OP_MAXU = 3'd4, // unsigned max
		OP_MINU = 3'd5, // unsigned min
		OP_MAXS = 3'd6, // signed max
		OP_MINS = 3'd7  // signed min
	} cmp_op_e;

	localparam int     WORD_WIDTH = 16;   // operand width
	localparam speed_e CMP_SPEED  = FAST; // architecture built at top level

	// one request, 3 + 2*16 bits
	typedef struct packed {
		cmp_op_e               op;
		logic [WORD_WIDTH-1:0] a;
		logic [WORD_WIDTH-1:0] b;
	} cmp_req_t;

	// one result, 16 + 1 + 1 bits
	typedef struct packed {
		logic [WORD_WIDTH-1:0] value; // selected operand, zero if no selection
		logic                  flag;  // boolean answer, or a-was-selected
		logic                  eq;    // operands equal
	} cmp_res_t;

endpackage

// File: prefix_and_or.sv
// parallel-prefix and-or network over generate/propagate pairs
// go[i] and po[i] cover bits i down to 0, sklansky, brent-kung or serial
`timescale 1ns/1ps

module prefix_and_or #(
	parameter int              width = 8,             // word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST  // network architecture
) (
	input  logic [width-1:0] gi, // generate in
	input  logic [width-1:0] pi, // propagate in
	output logic [width-1:0] go, // prefix generate out
	output logic [width-1:0] po  // prefix propagate out
);

	import lau_pkg::*;

	localparam int m    = $clog2(width);          // tree depth
	localparam int bk_n = (m > 0) ? 2 * m - 1 : 0; // brent-kung stage count

	if (speed == FAST) begin : g_sklansky
		// sklansky, m levels, upper half of each block taps top of lower half
		logic [width-1:0] gt [0:m];
		logic [width-1:0] pt [0:m];

		assign gt[0] = gi;
		assign pt[0] = pi;

		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar i = 0; i < width; i++) begin : g_bit
				if ((i / 2**(l-1)) % 2 == 1) begin : g_black
					localparam int j = (i / 2**l) * 2**l + 2**(l-1) - 1; // lower half top
					assign gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][j]);
					assign pt[l][i] = pt[l-1][i] & pt[l-1][j];
				end else begin : g_white
					assign gt[l][i] = gt[l-1][i]; // pass through
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign go = gt[m];
		assign po = pt[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		// up-sweep builds power-of-two spans, down-sweep fills the gaps
		logic [width-1:0] gt [0:bk_n];
		logic [width-1:0] pt [0:bk_n];

		assign gt[0] = gi;
		assign pt[0] = pi;

		// up-sweep, stage l joins spans of 2**(l-1)
		for (genvar l = 1; l <= m; l++) begin : g_up
			for (genvar i = 0; i < width; i++) begin : g_bit
				if ((i + 1) % 2**l == 0) begin : g_black
					localparam int j = i - 2**(l-1);
					assign gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][j]);
					assign pt[l][i] = pt[l-1][i] & pt[l-1][j];
				end else begin : g_white
					assign gt[l][i] = gt[l-1][i];
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// down-sweep, stage s works at span lev = 2m - s
		for (genvar s = m + 1; s <= bk_n; s++) begin : g_down
			localparam int lev = 2 * m - s;
			for (genvar i = 0; i < width; i++) begin : g_bit
				if (((i + 1) % 2**lev == 2**(lev-1)) && (i >= 2**lev)) begin : g_black
					localparam int j = i - 2**(lev-1); // already a full prefix
					assign gt[s][i] = gt[s-1][i] | (pt[s-1][i] & gt[s-1][j]);
					assign pt[s][i] = pt[s-1][i] & pt[s-1][j];
				end else begin : g_white
					assign gt[s][i] = gt[s-1][i];
					assign pt[s][i] = pt[s-1][i];
				end
			end
		end

		assign go = gt[bk_n];
		assign po = pt[bk_n];
	end else begin : g_serial
		// ripple chain, width-1 cells deep
		logic [width-1:0] gt;
		logic [width-1:0] pt;

		assign gt[0] = gi[0];
		assign pt[0] = pi[0];

		for (genvar i = 1; i < width; i++) begin : g_bit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]);
			assign pt[i] = pi[i] & pt[i-1];
		end

		assign go = gt;
		assign po = pt;
	end

endmodule

// File: cmp_ge.sv
// magnitude comparator without subtraction
// ge = (a >= b) and eq = (a == b) from one prefix and-or network
`timescale 1ns/1ps

module cmp_ge #(
	parameter int              width = 8,             // word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST  // network architecture
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic             ge, // a >= b unsigned
	output logic             eq  // a == b
);

	logic [width-1:0] gi; // per-bit a wins
	logic [width-1:0] pi; // per-bit equal
	logic [width-1:0] go;
	logic [width-1:0] po;

	// lsb generates on a tie too, so equal words resolve to ge
	assign gi[0] = a[0] | ~b[0];
	assign pi[0] = ~(a[0] ^ b[0]);

	for (genvar i = 1; i < width; i++) begin : g_pre
		assign gi[i] = a[i] & ~b[i];
		assign pi[i] = ~(a[i] ^ b[i]);
	end

	prefix_and_or #(
		.width(width),
		.speed(speed)
	) u_prefix (
		.gi(gi),
		.pi(pi),
		.go(go),
		.po(po)
	);

	assign ge = go[width-1]; // msb-first decision
	assign eq = po[width-1]; // all bits equal

endmodule

// File: cmp_in_stage.sv
// input register stage
// strobe register with reset, request register loaded on valid
`timescale 1ns/1ps

module cmp_in_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  lau_pkg::cmp_req_t in_req,
	output logic              req_valid,
	output lau_pkg::cmp_req_t req
);

	import lau_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= in_valid; // one pulse per request
		end
	end

	// payload held between requests
	always_ff @(posedge clk) begin
		if (in_valid) begin
			req <= in_req;
		end
	end

	// a strobed request must carry a known opcode
	a_op_defined: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> in_req.op inside {OP_GEU, OP_LTU, OP_EQ, OP_GES,
			OP_MAXU, OP_MINU, OP_MAXS, OP_MINS})
		else $error("undefined opcode %b on strobed request", in_req.op);

endmodule

// File: cmp_core.sv
// comparator processing core, combinational
// sign conditioning, magnitude compare and opcode decode into a result
`timescale 1ns/1ps

module cmp_core (
	input  logic              req_valid,
	input  lau_pkg::cmp_req_t req,
	output logic              res_valid,
	output lau_pkg::cmp_res_t res
);

	import lau_pkg::*;

	logic                  signed_op; // two's complement ordering wanted
	logic [WORD_WIDTH-1:0] ca;        // conditioned operands
	logic [WORD_WIDTH-1:0] cb;
	logic                  ge_flag;
	logic                  eq_flag;

	assign signed_op = (req.op == OP_GES) || (req.op == OP_MAXS) || (req.op == OP_MINS);

	// flipping the sign bit maps signed order onto unsigned order
	assign ca = {req.a[WORD_WIDTH-1] ^ signed_op, req.a[WORD_WIDTH-2:0]};
	assign cb = {req.b[WORD_WIDTH-1] ^ signed_op, req.b[WORD_WIDTH-2:0]};

	cmp_ge #(
		.width(WORD_WIDTH),
		.speed(CMP_SPEED)
	) u_cmp_ge (
		.a (ca),
		.b (cb),
		.ge(ge_flag),
		.eq(eq_flag)
	);

	// opcode decode
	always_comb begin
		res       = '0;
		res.eq    = eq_flag; // equality reported for every op
		case (req.op)
			OP_GEU, OP_GES: begin
				res.flag = ge_flag;
			end
			OP_LTU: begin
				res.flag = ~ge_flag;
			end
			OP_EQ: begin
				res.flag = eq_flag;
			end
			OP_MAXU, OP_MAXS: begin
				res.flag  = ge_flag;                   // a picked when a >= b
				res.value = ge_flag ? req.a : req.b;
			end
			OP_MINU, OP_MINS: begin
				res.flag  = ~ge_flag;                  // a picked only when a < b
				res.value = ge_flag ? req.b : req.a;   // tie returns b
			end
			default: begin
				res.flag = 1'b0;
			end
		endcase
	end

	assign res_valid = req_valid; // no latency in the core

	// equal words must also compare as ge through the prefix network
	always_comb begin
		if (req_valid) begin
			a_eq_implies_ge: assert #0 (!eq_flag || ge_flag)
				else $error("comparator reports eq without ge");
		end
	end

endmodule

// File: cmp_out_stage.sv
// output register stage
// valid pulse register with reset, result register loaded on valid
`timescale 1ns/1ps

module cmp_out_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              res_valid,
	input  lau_pkg::cmp_res_t res,
	output logic              out_valid,
	output lau_pkg::cmp_res_t out_res
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= res_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			out_res <= res; // held until next result
		end
	end

	// quiet output right after reset
	a_idle_after_reset: assert property (@(posedge clk)
		reset |=> !out_valid)
		else $error("out_valid high in cycle after reset");

	// one result pulse per core pulse, one cycle later
	a_valid_follows: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (out_valid == $past(res_valid)))
		else $error("out_valid does not track res_valid by one cycle");

endmodule

// File: lau_cmp_top.sv
// pipelined word comparator, two cycles from request to result
// input register, combinational compare core, output register
`timescale 1ns/1ps

module lau_cmp_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  lau_pkg::cmp_req_t in_req,
	output logic              out_valid,
	output lau_pkg::cmp_res_t out_res
);

	import lau_pkg::*;

	logic     req_valid; // stage 1 strobe
	cmp_req_t req;       // stage 1 request
	logic     res_valid; // core strobe
	cmp_res_t res;       // core result

	cmp_in_stage u_in_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_req   (in_req),
		.req_valid(req_valid),
		.req      (req)
	);

	cmp_core u_core (
		.req_valid(req_valid),
		.req      (req),
		.res_valid(res_valid),
		.res      (res)
	);

	cmp_out_stage u_out_stage (
		.clk      (clk),
		.reset    (reset),
		.res_valid(res_valid),
		.res      (res),
		.out_valid(out_valid),
		.out_res  (out_res)
	);

endmodule

// File: tb_lau_cmp.sv
// testbench for the pipelined word comparator
// directed, streaming and gapped requests checked against a reference model
`timescale 1ns/1ps

module tb_lau_cmp;

	import lau_pkg::*;

	localparam int N_DIR     = 64;  // directed requests
	localparam int N_RAND    = 400; // back-to-back random requests
	localparam int N_GAP     = 100; // gapped random requests
	localparam int MAX_GAP   = 3;   // idle cycles at most between gapped requests
	localparam int LAT_NEG   = 3;   // negedges from drive edge to result
	localparam int WD_CYCLES = (N_DIR + N_RAND + N_GAP * (MAX_GAP + 1)) * 2 + 100;
	localparam int WD_NS     = WD_CYCLES * 4;

	// expected result stamped with the negedge count at drive time
	typedef struct packed {
		cmp_res_t    res;
		logic [31:0] stamp;
	} exp_t;

	logic     clk;
	logic     reset;
	logic     in_valid;
	cmp_req_t in_req;
	logic     out_valid;
	cmp_res_t out_res;

	exp_t        exp_q [$]; // results in flight
	exp_t        e;
	int          seed     = 79039;
	int          errors   = 0;
	int          sent     = 0;
	int          received = 0;
	logic [31:0] neg_cnt  = 0;
	logic        reset_d  = 1'b1; // reset seen at previous negedge

	lau_cmp_top uut (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_req   (in_req),
		.out_valid(out_valid),
		.out_res  (out_res)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// expected result from plain signed and unsigned comparisons
	function automatic cmp_res_t ref_cmp(cmp_req_t r);
		cmp_res_t                     x;
		logic signed [WORD_WIDTH-1:0] sa;
		logic signed [WORD_WIDTH-1:0] sb;
		x  = '0;
		sa = r.a;
		sb = r.b;
		x.eq = (r.a == r.b);
		case (r.op)
			OP_GEU:  x.flag = (r.a >= r.b);
			OP_LTU:  x.flag = (r.a < r.b);
			OP_EQ:   x.flag = (r.a == r.b);
			OP_GES:  x.flag = (sa >= sb);
			OP_MAXU: x.flag = (r.a >= r.b); // a taken on tie
			OP_MINU: x.flag = (r.a < r.b);  // b taken on tie
			OP_MAXS: x.flag = (sa >= sb);
			OP_MINS: x.flag = (sa < sb);
			default: x.flag = 1'b0;
		endcase
		if (r.op inside {OP_MAXU, OP_MINU, OP_MAXS, OP_MINS})
			x.value = x.flag ? r.a : r.b; // flag means a was selected
		return x;
	endfunction

	// one request on the next rising edge, expectation queued
	task automatic send(input cmp_op_e op, input logic [WORD_WIDTH-1:0] a,
			input logic [WORD_WIDTH-1:0] b);
		cmp_req_t r;
		r.op = op;
		r.a  = a;
		r.b  = b;
		@(posedge clk);
		in_valid <= 1'b1;
		in_req   <= r;
		exp_q.push_back({ref_cmp(r), neg_cnt});
		sent++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic send_random();
		int          rnd;
		logic [15:0] a;
		logic [15:0] b;
		rnd = $random(seed);
		a   = rnd[15:0];
		rnd = $random(seed);
		b   = (rnd[31:29] == 3'd0) ? a : rnd[15:0]; // some ties
		send(cmp_op_e'(rnd[18:16]), a, b);
	endtask

	task automatic unsigned_pair(input logic [15:0] a, input logic [15:0] b);
		send(OP_GEU, a, b);
		send(OP_LTU, a, b);
		send(OP_EQ, a, b);
	endtask

	task automatic signed_pair(input logic [15:0] a, input logic [15:0] b);
		send(OP_GES, a, b);
		send(OP_MAXS, a, b);
		send(OP_MINS, a, b);
	endtask

	task automatic select_pair(input logic [15:0] a, input logic [15:0] b);
		send(OP_MAXU, a, b);
		send(OP_MINU, a, b);
		send(OP_MAXS, a, b);
		send(OP_MINS, a, b);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expv,
			input logic [31:0] got);
		errors++;
		$display("[FAIL] %0t %s expected %0h got %0h", $time, name, expv, got);
	endtask

	// result checker, samples mid-cycle
	always @(negedge clk) begin
		neg_cnt = neg_cnt + 1;
		if (reset || reset_d) begin
			if (out_valid !== 1'b0) begin
				errors++;
				$display("out_valid not low during reset or right after it at %0t", $time);
			end
		end else if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result appeared at %0t with no request outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				received++;
				if (neg_cnt != e.stamp + LAT_NEG)
					report_mismatch("latency", e.stamp + LAT_NEG, neg_cnt);
				if (out_res.value !== e.res.value)
					report_mismatch("out_res.value", e.res.value, out_res.value);
				if (out_res.flag !== e.res.flag)
					report_mismatch("out_res.flag", e.res.flag, out_res.flag);
				if (out_res.eq !== e.res.eq)
					report_mismatch("out_res.eq", e.res.eq, out_res.eq);
			end
		end else if (out_valid !== 1'b0) begin
			errors++;
			$display("out_valid unknown at %0t", $time);
		end
		reset_d = reset;
	end

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		in_req   = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		idle(3); // quiet cycles, nothing may come out

		// unsigned and equality corners
		unsigned_pair(16'h1234, 16'h1234);
		unsigned_pair(16'h0001, 16'h0000); // lsb only
		unsigned_pair(16'h0000, 16'h0001);
		unsigned_pair(16'h8000, 16'h0000); // msb only
		unsigned_pair(16'h0000, 16'h8000);
		unsigned_pair(16'h0000, 16'h0000);
		unsigned_pair(16'hffff, 16'hffff);
		unsigned_pair(16'h0000, 16'hffff);
		unsigned_pair(16'hffff, 16'h0000);

		// mixed sign pairs
		signed_pair(16'hffff, 16'h0000); // -1 vs 0
		signed_pair(16'h0000, 16'hffff);
		signed_pair(16'h8000, 16'h7fff); // most negative vs most positive
		signed_pair(16'h7fff, 16'h8000);
		signed_pair(16'h8000, 16'h8000);
		signed_pair(16'hfff6, 16'h000a);
		signed_pair(16'h8000, 16'hffff);

		// operand selection
		select_pair(16'h1234, 16'h4321);
		select_pair(16'h4321, 16'h1234);
		select_pair(16'h5555, 16'h5555); // tie
		select_pair(16'h8001, 16'h0001);
		idle(4);

		// back-to-back stream
		repeat (N_RAND) send_random();
		idle(4);

		// gapped traffic
		repeat (N_GAP) begin
			send_random();
			idle(($random(seed) & 32'h7fffffff) % MAX_GAP + 1);
		end

		idle(8); // two-cycle pipe drains and any stray pulse shows up
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d results never arrived", exp_q.size());
		end
		if (received != sent) begin
			errors++;
			$display("sent %0d requests but got %0d results", sent, received);
		end
		$display("errors: %0d, requests: %0d, results: %0d", errors, sent, received);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog sized from the vector counts
	initial begin
		#(WD_NS);
		$display("watchdog expired with %0d results outstanding", exp_q.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: lau_cmp.f
lau_pkg.sv
prefix_and_or.sv
cmp_ge.sv
cmp_in_stage.sv
cmp_core.sv
cmp_out_stage.sv
lau_cmp_top.sv
tb_lau_cmp.sv
